/* fft_capture_pkg.sv */
// shared sizes and types for the frame capture unit
// sample and write request structs, buffer state and phase enums
// signed bit-width rule used for block floating-point tracking

package fft_capture_pkg;

   //////////////////////////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////////////////////////
   localparam int FRAME_LEN  = 16;
   localparam int FRAME_BITS = 4;
   localparam int SAMPLE_DW  = 16;
   localparam int BW_DW      = 5;

   //////////////////////////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////////////////////////
   // imag sits in the upper half
   typedef struct packed {
      logic signed [SAMPLE_DW-1:0] im;
      logic signed [SAMPLE_DW-1:0] re;
   } sample_t;

   // one write into the bank being filled
   typedef struct packed {
      logic                  act;
      logic [FRAME_BITS-1:0] addr;
      sample_t               data;
   } wr_req_t;

   typedef enum logic [1:0] {
      IBUF_IDLE   = 2'h0,
      IBUF_STREAM = 2'h1,
      IBUF_FULL   = 2'h2
   } ibuf_state_t;

   typedef enum logic [1:0] {
      PHASE_0,
      PHASE_1,
      PHASE_2
   } phase_t;

   // bits needed for a signed value, never less than 1
   function automatic logic [BW_DW-1:0] sample_bw(input logic signed [SAMPLE_DW-1:0] v);
      logic [BW_DW-1:0] bw;
      bw = 1;
      for (int i = 0; i < SAMPLE_DW - 1; i++) begin
         if (v[i] != v[SAMPLE_DW-1]) begin
            bw = BW_DW'(i + 2);
         end
      end
      return bw;
   endfunction

endpackage

/* stream_capture.sv */
// input-buffer FSM for the sample stream
// accepted-sample counter with bit-reversed write address

`timescale 1ns/1ps

module stream_capture (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run,
   input  logic                         in_valid,
   input  fft_capture_pkg::sample_t     in_sample,
   output fft_capture_pkg::ibuf_state_t buf_status,
   output fft_capture_pkg::wr_req_t     wr_req
);

   logic [fft_capture_pkg::FRAME_BITS-1:0] count;
   logic                                   accept;
   logic                                   last_sample;
   fft_capture_pkg::ibuf_state_t           state_n;

   // samples only land while streaming, dropped when full
   assign accept      = in_valid && (buf_status == fft_capture_pkg::IBUF_STREAM);
   assign last_sample = (int'(count) == fft_capture_pkg::FRAME_LEN - 1);

   assign wr_req.act  = accept;
   assign wr_req.addr = {<<{count}};
   assign wr_req.data = in_sample;

   //////////////////////////////////////////////////////////////////////
   // state machine
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      case (buf_status)
         fft_capture_pkg::IBUF_IDLE: begin
            state_n = fft_capture_pkg::IBUF_STREAM;
         end
         fft_capture_pkg::IBUF_STREAM: begin
            if (accept && last_sample) begin
               state_n = fft_capture_pkg::IBUF_FULL;
            end else begin
               state_n = fft_capture_pkg::IBUF_STREAM;
            end
         end
         fft_capture_pkg::IBUF_FULL: begin
            if (run) begin
               state_n = fft_capture_pkg::IBUF_STREAM;
            end else begin
               state_n = fft_capture_pkg::IBUF_FULL;
            end
         end
         default: begin
            state_n = fft_capture_pkg::IBUF_IDLE;
         end
      endcase
   end

   // count wraps to zero on the sixteenth sample
   always_ff @(posedge clk) begin
      if (rst) begin
         buf_status <= fft_capture_pkg::IBUF_IDLE;
         count      <= '0;
      end else begin
         buf_status <= state_n;
         if (run) begin
            count <= '0;
         end else if (accept) begin
            count <= count + 1'b1;
         end
      end
   end

endmodule

/* bit_width_tracker.sv */
// per-sample bit width of the incoming stream
// running frame maximum and two-stage alignment to the DMA bank

`timescale 1ns/1ps

module bit_width_tracker (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                run,
   input  fft_capture_pkg::wr_req_t            wr_req,
   output logic [fft_capture_pkg::BW_DW-1:0]   frame_bw
);

   logic [fft_capture_pkg::BW_DW-1:0] re_bw;
   logic [fft_capture_pkg::BW_DW-1:0] im_bw;
   logic [fft_capture_pkg::BW_DW-1:0] sample_max;
   logic [fft_capture_pkg::BW_DW-1:0] run_max;
   logic [fft_capture_pkg::BW_DW-1:0] mid_bw;

   assign re_bw = fft_capture_pkg::sample_bw(wr_req.data.re);
   assign im_bw = fft_capture_pkg::sample_bw(wr_req.data.im);

   // wider of the two parts
   always_comb begin
      if (re_bw > im_bw) begin
         sample_max = re_bw;
      end else begin
         sample_max = im_bw;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // frame maximum and width pipe
   //////////////////////////////////////////////////////////////////////
   // mid_bw follows the bank in its processing slot,
   // frame_bw the bank open for DMA
   always_ff @(posedge clk) begin
      if (rst) begin
         run_max  <= '0;
         mid_bw   <= '0;
         frame_bw <= '0;
      end else if (run) begin
         run_max  <= '0;
         mid_bw   <= run_max;
         frame_bw <= mid_bw;
      end else if (wr_req.act && (sample_max > run_max)) begin
         run_max <= sample_max;
      end
   end

endmodule

/* tri_bank_store.sv */
// three-phase bank rotation on run
// three capture banks split into even and odd halves
// write routing by phase and address LSB, registered DMA read

`timescale 1ns/1ps

module tri_bank_store (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   run,
   input  fft_capture_pkg::wr_req_t               wr_req,
   input  logic                                   dma_act,
   input  logic [fft_capture_pkg::FRAME_BITS-1:0] dma_addr,
   output fft_capture_pkg::sample_t               dma_data
);

   localparam int HALF_BITS = fft_capture_pkg::FRAME_BITS - 1;

   fft_capture_pkg::phase_t   phase;
   fft_capture_pkg::phase_t   next_phase;

   // banks indexed by phase, halves by address LSB
   fft_capture_pkg::sample_t  mem_even [3][fft_capture_pkg::FRAME_LEN/2];
   fft_capture_pkg::sample_t  mem_odd  [3][fft_capture_pkg::FRAME_LEN/2];

   fft_capture_pkg::sample_t  even_q;
   fft_capture_pkg::sample_t  odd_q;
   logic                      lsb_q;

   //////////////////////////////////////////////////////////////////////
   // rotation
   //////////////////////////////////////////////////////////////////////
   // phase plus one modulo 3, also the bank open for DMA
   always_comb begin
      case (phase)
         fft_capture_pkg::PHASE_0: begin
            next_phase = fft_capture_pkg::PHASE_1;
         end
         fft_capture_pkg::PHASE_1: begin
            next_phase = fft_capture_pkg::PHASE_2;
         end
         default: begin
            next_phase = fft_capture_pkg::PHASE_0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= fft_capture_pkg::PHASE_0;
      end else if (run) begin
         phase <= next_phase;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_req.act) begin
         if (wr_req.addr[0]) begin
            mem_odd[phase][wr_req.addr[HALF_BITS:1]] <= wr_req.data;
         end else begin
            mem_even[phase][wr_req.addr[HALF_BITS:1]] <= wr_req.data;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // DMA read
   //////////////////////////////////////////////////////////////////////
   // both halves fetched, held until the next dma_act
   always_ff @(posedge clk) begin
      if (rst) begin
         even_q <= '0;
         odd_q  <= '0;
         lsb_q  <= 1'b0;
      end else if (dma_act) begin
         even_q <= mem_even[next_phase][dma_addr[HALF_BITS:1]];
         odd_q  <= mem_odd[next_phase][dma_addr[HALF_BITS:1]];
         lsb_q  <= dma_addr[0];
      end
   end

   assign dma_data = lsb_q ? odd_q : even_q;

endmodule

/* fft_capture_top.sv */
// top level of the triple-buffered frame capture unit
// stream capture, frame width tracking and bank storage

`timescale 1ns/1ps

module fft_capture_top (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   run,
   input  logic                                   in_valid,
   input  fft_capture_pkg::sample_t               in_sample,
   input  logic                                   dma_act,
   input  logic [fft_capture_pkg::FRAME_BITS-1:0] dma_addr,
   output fft_capture_pkg::ibuf_state_t           buf_status,
   output logic [fft_capture_pkg::BW_DW-1:0]      frame_bw,
   output fft_capture_pkg::sample_t               dma_data
);

   fft_capture_pkg::wr_req_t wr_req;

   stream_capture u_capture (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .in_valid   (in_valid),
      .in_sample  (in_sample),
      .buf_status (buf_status),
      .wr_req     (wr_req)
   );

   bit_width_tracker u_width (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .wr_req   (wr_req),
      .frame_bw (frame_bw)
   );

   tri_bank_store u_store (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .wr_req   (wr_req),
      .dma_act  (dma_act),
      .dma_addr (dma_addr),
      .dma_data (dma_data)
   );

endmodule

/* capture_props.sv */
// concurrent assertions on the capture FSM and DMA read timing
// bound into the capture top level

`timescale 1ns/1ps

module capture_props (
   input logic                         clk,
   input logic                         rst,
   input logic                         run,
   input fft_capture_pkg::ibuf_state_t buf_status,
   input fft_capture_pkg::wr_req_t     wr_req,
   input logic                         dma_act,
   input fft_capture_pkg::sample_t     dma_data
);

   // the last address of a frame fills the buffer
   full_after_last_write: assert property (
      @(posedge clk) disable iff (rst)
      (wr_req.act && (wr_req.addr == '1))
         |=> (buf_status == fft_capture_pkg::IBUF_FULL)
   ) else $error("input buffer not full after the last write of a frame");

   not_full_after_run: assert property (
      @(posedge clk) disable iff (rst)
      run |=> (buf_status != fft_capture_pkg::IBUF_FULL)
   ) else $error("input buffer still full after a run pulse");

   // read data only moves after a DMA request
   dma_data_held: assert property (
      @(posedge clk) disable iff (rst)
      !dma_act |=> $stable(dma_data)
   ) else $error("dma_data changed without a DMA request");

endmodule

/* capture_tb.sv */
// testbench for the frame capture unit
// clock, reset, stimulus from capture_stim.txt, reference model
// value checks, watchdog and closing count line

`timescale 1ns/1ps

module capture_tb;

   localparam int FRAME_LEN   = fft_capture_pkg::FRAME_LEN;
   localparam int ADDR_W      = $clog2(FRAME_LEN);
   localparam int PART_W      = $bits(fft_capture_pkg::sample_t) / 2;
   localparam int PERIOD      = 40;
   localparam int STIM_WORDS  = 3 * FRAME_LEN + 4;
   localparam int MAX_GAP     = 3;
   localparam int READ_CYCLES = 2 * (FRAME_LEN + 4);
   localparam int WATCHDOG_NS = (STIM_WORDS * (MAX_GAP + 1) + READ_CYCLES) * PERIOD * 2;

   logic                                  clk;
   logic                                  rst;
   logic                                  run;
   logic                                  in_valid;
   fft_capture_pkg::sample_t              in_sample;
   logic                                  dma_act;
   logic [ADDR_W-1:0]                     dma_addr;
   fft_capture_pkg::ibuf_state_t          buf_status;
   logic [fft_capture_pkg::BW_DW-1:0]     frame_bw;
   fft_capture_pkg::sample_t              dma_data;

   logic [31:0] stim_mem [0:STIM_WORDS-1];
   logic [31:0] ref_bank [0:2][0:FRAME_LEN-1];
   int          ref_bw   [0:2];
   integer      seed;
   int          check_count;
   int          error_count;

   fft_capture_top u_dut (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .in_valid   (in_valid),
      .in_sample  (in_sample),
      .dma_act    (dma_act),
      .dma_addr   (dma_addr),
      .buf_status (buf_status),
      .frame_bw   (frame_bw),
      .dma_data   (dma_data)
   );

   bind fft_capture_top capture_props u_props (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .buf_status (buf_status),
      .wr_req     (wr_req),
      .dma_act    (dma_act),
      .dma_data   (dma_data)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: capture sequence did not complete within %0d ns", WATCHDOG_NS);
      $display("Simulation FAILED");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////
   function automatic logic [ADDR_W-1:0] bit_reverse(input logic [ADDR_W-1:0] v);
      logic [ADDR_W-1:0] r;
      for (int i = 0; i < ADDR_W; i++) begin
         r[i] = v[ADDR_W-1-i];
      end
      return r;
   endfunction

   // fold negatives onto their complement, then find the top set bit
   function automatic int part_width(input logic signed [PART_W-1:0] v);
      logic [PART_W-1:0] mag;
      int                w;
      mag = v[PART_W-1] ? ~v : v;
      w = 1;
      for (int i = 0; i < PART_W; i++) begin
         if (mag[i]) begin
            w = i + 2;
         end
      end
      return w;
   endfunction

   task automatic build_model();
      fft_capture_pkg::sample_t s;
      int                       w;
      for (int f = 0; f < 3; f++) begin
         ref_bw[f] = 0;
         for (int k = 0; k < FRAME_LEN; k++) begin
            s = stim_mem[f * FRAME_LEN + k];
            ref_bank[f][bit_reverse(ADDR_W'(k))] = s;
            w = part_width(s.re);
            if (part_width(s.im) > w) begin
               w = part_width(s.im);
            end
            if (w > ref_bw[f]) begin
               ref_bw[f] = w;
            end
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus and checks
   //////////////////////////////////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("error at time %0t: %s expected 0x%h, got 0x%h", $time, name, expected,
                  actual);
      end
   endtask

   // random idle gap before each sample
   task automatic capture_frame(input int first);
      int gap;
      for (int k = 0; k < FRAME_LEN; k++) begin
         gap = $unsigned($random(seed)) % (MAX_GAP + 1);
         repeat (gap) @(negedge clk);
         in_valid  = 1'b1;
         in_sample = stim_mem[first + k];
         @(negedge clk);
         in_valid  = 1'b0;
      end
      check_value("buf_status", 32'(fft_capture_pkg::IBUF_FULL), 32'(buf_status));
   endtask

   task automatic send_while_full(input int first, input int count);
      for (int k = 0; k < count; k++) begin
         in_valid  = 1'b1;
         in_sample = stim_mem[first + k];
         @(negedge clk);
      end
      in_valid = 1'b0;
      check_value("buf_status", 32'(fft_capture_pkg::IBUF_FULL), 32'(buf_status));
   endtask

   task automatic pulse_run();
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      check_value("buf_status", 32'(fft_capture_pkg::IBUF_STREAM), 32'(buf_status));
   endtask

   // data shows up one cycle after each address
   task automatic read_frame(input int f);
      logic [ADDR_W-1:0] a;
      check_value("frame_bw", 32'(ref_bw[f]), 32'(frame_bw));
      for (int i = 0; i < FRAME_LEN; i++) begin
         a        = ADDR_W'(i);
         dma_act  = 1'b1;
         dma_addr = a;
         @(negedge clk);
         check_value($sformatf("dma_data[%0d]", i), ref_bank[f][a], dma_data);
      end
      dma_act = 1'b0;
      repeat (2) @(negedge clk);
      check_value("dma_data", ref_bank[f][FRAME_LEN-1], dma_data);
   endtask

   initial begin
      seed        = 32'h2e9e;
      check_count = 0;
      error_count = 0;
      rst         = 1'b1;
      run         = 1'b0;
      in_valid    = 1'b0;
      in_sample   = '0;
      dma_act     = 1'b0;
      dma_addr    = '0;
      $readmemh("capture_stim.txt", stim_mem);
      build_model();

      repeat (3) @(posedge clk);
      @(negedge clk);
      check_value("buf_status", 32'(fft_capture_pkg::IBUF_IDLE), 32'(buf_status));
      rst = 1'b0;
      @(negedge clk);
      check_value("buf_status", 32'(fft_capture_pkg::IBUF_STREAM), 32'(buf_status));
      check_value("frame_bw", 32'd0, 32'(frame_bw));
      check_value("dma_data", 32'd0, dma_data);

      // frame A, then the trailing samples that must be dropped
      capture_frame(0);
      send_while_full(3 * FRAME_LEN, 4);
      pulse_run();
      check_value("frame_bw", 32'd0, 32'(frame_bw));
      capture_frame(FRAME_LEN);
      pulse_run();
      read_frame(0);

      // frame C goes into the third bank, B comes up for DMA
      capture_frame(2 * FRAME_LEN);
      pulse_run();
      read_frame(1);

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* capture_stim.txt */
// two samples per line, each word is imag (upper 16 bits) then real, hex
// frames A, B, C of sixteen samples each, then four samples sent while full
00030005 fffd0002
00000000 007f0010
ff80fff0 00010001
fffffffe 000a0007
0020ffc0 fff8001f
00400000 ffe00033
00000000 0005fffb
0011ff91 003c0002
12345678 8000ffff
01230456 fedc0ba9
00007fff 3c3c0000
0f0ff0f0 55aaaa55
00010002 00030004
ffff0000 0000ffff
7ffe8001 04000200
c0004000 00110022
01010202 03030404
05050606 07070808
09090a0a 0b0b0c0c
0d0d0e0e 0f0f1010
11111212 13131414
15151616 17171818
19191a1a 1b1b1c1c
1d1d1e1e 1f1f2020
7fff7fff deadbeef
80008000 cafef00d

/* verilog.f */
fft_capture_pkg.sv
stream_capture.sv
bit_width_tracker.sv
tri_bank_store.sv
fft_capture_top.sv
capture_props.sv
capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the frame capture testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module capture_tb -f verilog.f -o capture_sim \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/capture_sim)
echo "$out"
echo "$out" | grep -q "^Simulation PASSED$" && echo "run passed" && exit 0 \
   || { echo "run failed"; exit 1; }
